//--- project.f
hw/viterbi_pkg.sv
hw/frame_ctrl.sv
hw/step_counter.sv
hw/acs_array.sv
hw/survivor_mem.sv
hw/traceback_unit.sv
hw/viterbi_decoder.sv
verif/tb_viterbi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the Viterbi decoder testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_viterbi \
   -Mdir "$build_dir" \
   -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/Vtb_viterbi" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
   exit 1
fi

if ! grep -q "TEST OK" "$log_file"; then
   echo "simulation ended without a result line"
   exit 1
fi

exit 0

//--- verif/tb_viterbi.sv
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi
   import viterbi_pkg::*;
();

   localparam int unsigned SEED             = 32'h54c16141;
   localparam int          N_CLEAN          = 20;
   localparam int          N_ERR            = 20;
   localparam int          N_BP             = 10;
   localparam int          IDLE_MAX         = 3;
   localparam int          OUT_DELAY_MAX    = 20;
   localparam int          CODE_W           = 2 * NUM_STEPS;
   // Worst case per symbol is idle time plus two cycles for each handshake edge
   localparam int          SYM_CYCLES_MAX   = 8;
   localparam int          FRAME_CYCLES_MAX = NUM_STEPS * SYM_CYCLES_MAX + NUM_STEPS
                                              + OUT_DELAY_MAX + 8;
   localparam int          CYCLE_LIMIT      = (N_CLEAN + N_ERR + N_BP) * FRAME_CYCLES_MAX + 100;

   logic        clk = 1'b0;
   logic        rst;
   logic        in_req_i;
   logic        in_ack_o;
   rx_sym_t     in_sym_i;
   logic        out_req_o;
   logic        out_ack_i;
   frame_word_t out_data_o;

   int check_count = 0;
   int error_count = 0;
   int cycle_count = 0;

   // Handshake history sampled on the rising edge
   logic        prev_in_req   = 1'b0;
   logic        prev_in_ack   = 1'b0;
   logic        prev_out_req  = 1'b0;
   logic        prev_out_ack  = 1'b0;
   frame_word_t prev_out_data = '0;
   logic        out_pending   = 1'b0;

   viterbi_decoder i_dut (
      .clk        (clk),
      .rst        (rst),
      .in_req_i   (in_req_i),
      .in_ack_o   (in_ack_o),
      .in_sym_i   (in_sym_i),
      .out_req_o  (out_req_o),
      .out_ack_i  (out_ack_i),
      .out_data_o (out_data_o)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         $display("mismatch %s: got %h expected %h", name, got, expected);
         error_count++;
      end
   endtask

   // Model encoder from state 0, message bit 0 first, then the zero tail
   function automatic logic [CODE_W-1:0] encode_word(input frame_word_t word);
      logic [STATE_W-1:0] enc_state;
      logic [STATE_W:0]   taps;
      logic               bit_in;
      logic [CODE_W-1:0]  code;
      enc_state = '0;
      code      = '0;
      for (int k = 0; k < NUM_STEPS; k++) begin
         bit_in        = (k < MSG_BITS) ? word[k] : 1'b0;
         taps          = {bit_in, enc_state};
         code[2*k+1]   = ^(taps & GEN0);
         code[2*k]     = ^(taps & GEN1);
         enc_state     = {bit_in, enc_state[STATE_W-1:1]};
      end
      return code;
   endfunction

   task automatic send_symbol(input rx_sym_t sym);
      int idle;
      idle = $urandom_range(IDLE_MAX);
      repeat (idle) @(negedge clk);
      in_sym_i = sym;
      in_req_i = 1'b1;
      @(negedge clk);
      while (!in_ack_o) @(negedge clk);
      in_req_i = 1'b0;
      @(negedge clk);
      while (in_ack_o) @(negedge clk);
   endtask

   task automatic send_frame(input logic [CODE_W-1:0] code);
      rx_sym_t sym;
      for (int k = 0; k < NUM_STEPS; k++) begin
         sym = code[2*k +: 2];
         send_symbol(sym);
      end
   endtask

   task automatic recv_frame(input frame_word_t expected, input int max_delay);
      int delay;
      while (!out_req_o) @(negedge clk);
      delay = $urandom_range(max_delay);
      repeat (delay) @(negedge clk);
      check_value("out_data_o", out_data_o, expected);
      out_ack_i = 1'b1;
      @(negedge clk);
      while (out_req_o) @(negedge clk);
      out_ack_i = 1'b0;
      @(negedge clk);
   endtask

   // Handshake order and output stability over the whole run
   always @(posedge clk) begin
      if (rst) begin
         if (in_ack_o && !prev_in_ack) begin
            check_value("in_req_i at in_ack_o rise", 32'(prev_in_req), 32'h1);
            check_value("output pending at in_ack_o rise", 32'(out_pending), 32'h0);
         end
         if (!out_req_o && prev_out_req) begin
            check_value("out_ack_i at out_req_o fall", 32'(prev_out_ack), 32'h1);
         end
         if (out_req_o && prev_out_req) begin
            check_value("out_data_o while out_req_o high", out_data_o, prev_out_data);
         end
      end
      prev_in_req   <= in_req_i;
      prev_in_ack   <= in_ack_o;
      prev_out_req  <= out_req_o;
      prev_out_ack  <= out_ack_i;
      prev_out_data <= out_data_o;
      if (out_req_o) begin
         out_pending <= 1'b1;
      end else if (!out_ack_i) begin
         out_pending <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the decoder stopped responding", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int                errs_before;
      int                flip_pos;
      frame_word_t       word;
      logic [CODE_W-1:0] code;
      frame_word_t       bp_words [N_BP];

      void'($urandom(SEED));
      rst       = 1'b0;
      in_req_i  = 1'b0;
      in_sym_i  = '0;
      out_ack_i = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b1;

      // Idle after reset
      errs_before = error_count;
      repeat (8) begin
         @(negedge clk);
         check_value("in_ack_o", 32'(in_ack_o), 32'h0);
         check_value("out_req_o", 32'(out_req_o), 32'h0);
      end
      $display("test 1 idle after reset done, %0d errors", error_count - errs_before);

      errs_before = error_count;
      for (int n = 0; n < N_CLEAN; n++) begin
         word = $urandom();
         send_frame(encode_word(word));
         recv_frame(word, IDLE_MAX);
      end
      $display("test 2 error-free frames done, %0d frames, %0d errors",
               N_CLEAN, error_count - errs_before);

      // One channel bit flipped anywhere in the frame
      errs_before = error_count;
      for (int n = 0; n < N_ERR; n++) begin
         word           = $urandom();
         code           = encode_word(word);
         flip_pos       = $urandom_range(CODE_W - 1);
         code[flip_pos] = ~code[flip_pos];
         send_frame(code);
         recv_frame(word, IDLE_MAX);
      end
      $display("test 3 single-error frames done, %0d frames, %0d errors",
               N_ERR, error_count - errs_before);

      // Next frame's first request waits behind a slow output ack
      errs_before = error_count;
      for (int n = 0; n < N_BP; n++) begin
         bp_words[n] = $urandom();
      end
      send_frame(encode_word(bp_words[0]));
      for (int n = 0; n < N_BP; n++) begin
         fork
            recv_frame(bp_words[n], OUT_DELAY_MAX);
            if (n < N_BP - 1) begin
               send_frame(encode_word(bp_words[n+1]));
            end
         join
      end
      $display("test 4 output back-pressure done, %0d frames, %0d errors",
               N_BP, error_count - errs_before);

      $display("test 5 handshake order done, checked over all frames");

      $display("%0d checks, %0d errors, %0d cycles", check_count, error_count, cycle_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_decoder
   import viterbi_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        in_req_i,
   output logic        in_ack_o,
   input  rx_sym_t     in_sym_i,
   output logic        out_req_o,
   input  logic        out_ack_i,
   output frame_word_t out_data_o
);

   logic              frame_clear;
   logic              accept;
   logic              step_inc;
   logic              trace;
   logic              step_last;
   logic              step_zero;
   logic [STEP_W-1:0] step;
   decision_t         acs_decision;
   decision_t         mem_decision;

   frame_ctrl u_frame_ctrl (
      .clk           (clk),
      .rst           (rst),
      .in_req_i      (in_req_i),
      .in_ack_o      (in_ack_o),
      .out_req_o     (out_req_o),
      .out_ack_i     (out_ack_i),
      .step_last_i   (step_last),
      .step_zero_i   (step_zero),
      .frame_clear_o (frame_clear),
      .accept_o      (accept),
      .step_inc_o    (step_inc),
      .trace_o       (trace)
   );

   // Counts up per symbol, back down during traceback
   step_counter u_step_counter (
      .clk     (clk),
      .rst     (rst),
      .clear_i (frame_clear),
      .inc_i   (step_inc),
      .dec_i   (trace),
      .step_o  (step),
      .last_o  (step_last),
      .zero_o  (step_zero)
   );

   acs_array u_acs_array (
      .clk        (clk),
      .rst        (rst),
      .clear_i    (frame_clear),
      .accept_i   (accept),
      .sym_i      (in_sym_i),
      .decision_o (acs_decision)
   );

   survivor_mem u_survivor_mem (
      .clk        (clk),
      .we_i       (accept),
      .addr_i     (step),
      .decision_i (acs_decision),
      .decision_o (mem_decision)
   );

   traceback_unit u_traceback_unit (
      .clk        (clk),
      .rst        (rst),
      .trace_i    (trace),
      .decision_i (mem_decision),
      .word_o     (out_data_o)
   );

endmodule

`default_nettype wire

//--- hw/traceback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module traceback_unit
   import viterbi_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        trace_i,
   input  decision_t   decision_i,
   output frame_word_t word_o
);

   logic [STATE_W-1:0] tb_state;
   frame_word_t        word;

   // Idle state is 0, the tail-terminated end of the trellis
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         tb_state <= '0;
      end else if (trace_i) begin
         tb_state <= {tb_state[STATE_W-2:0], decision_i[tb_state]};
      end else begin
         tb_state <= '0;
      end
   end

   // Top bit of each state is the input bit of that step,
   // tail bits fall off the top after the full walk
   always_ff @(posedge clk) begin
      if (trace_i) begin
         word <= {word[MSG_BITS-2:0], tb_state[STATE_W-1]};
      end
   end

   assign word_o = word;

   // Path must lead back to the start state of the frame
   assert property (@(posedge clk) disable iff (!rst) $fell(trace_i) |-> (tb_state == '0));

endmodule

`default_nettype wire

//--- hw/survivor_mem.sv
`timescale 1ns/1ps
`default_nettype none

module survivor_mem
   import viterbi_pkg::*;
(
   input  logic              clk,
   input  logic              we_i,
   input  logic [STEP_W-1:0] addr_i,
   input  decision_t         decision_i,
   output decision_t         decision_o
);

   // One decision vector per trellis step of the frame
   decision_t mem [NUM_STEPS];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= decision_i;
      end
   end

   // Read is combinational so traceback moves one step per cycle
   assign decision_o = mem[addr_i];

   // Counter must stay inside the frame when writing
   assert property (@(posedge clk) we_i |-> (addr_i < STEP_W'(NUM_STEPS)));

endmodule

`default_nettype wire

//--- hw/acs_array.sv
`timescale 1ns/1ps
`default_nettype none

module acs_array
   import viterbi_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      clear_i,
   input  logic      accept_i,
   input  rx_sym_t   sym_i,
   output decision_t decision_o
);

   logic [METRIC_W-1:0]   pm       [NUM_STATES];
   logic [METRIC_W-1:0]   pm_next  [NUM_STATES];
   logic [NUM_STATES-1:0] valid;
   logic [NUM_STATES-1:0] valid_next;

   // Hamming distance between the received pair and the pair
   // the encoder emits when entering ns with oldest bit b
   function automatic logic [1:0] branch_dist(logic [STATE_W-1:0] ns, logic b, rx_sym_t sym);
      logic [STATE_W:0] taps;
      rx_sym_t          expect_sym;
      taps          = {ns, b};
      expect_sym.c0 = ^(taps & GEN0);
      expect_sym.c1 = ^(taps & GEN1);
      return {1'b0, expect_sym.c0 ^ sym.c0} + {1'b0, expect_sym.c1 ^ sym.c1};
   endfunction

   for (genvar g = 0; g < NUM_STATES; g++) begin : g_acs
      logic [STATE_W-1:0]  ns;
      logic [STATE_W-1:0]  p0;
      logic [STATE_W-1:0]  p1;
      logic [METRIC_W-1:0] cand0;
      logic [METRIC_W-1:0] cand1;
      logic                take1;

      assign ns = STATE_W'(g);
      // Predecessors drop the top bit and shift in 0 or 1
      assign p0 = {ns[STATE_W-2:0], 1'b0};
      assign p1 = {ns[STATE_W-2:0], 1'b1};

      assign cand0 = pm[p0] + METRIC_W'(branch_dist(ns, 1'b0, sym_i));
      assign cand1 = pm[p1] + METRIC_W'(branch_dist(ns, 1'b1, sym_i));

      // Ties go to p0, an invalid predecessor always loses
      assign take1 = valid[p1] && (!valid[p0] || (cand1 < cand0));

      assign pm_next[g]    = take1 ? cand1 : cand0;
      assign valid_next[g] = valid[p0] | valid[p1];
      assign decision_o[g] = take1;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         valid <= NUM_STATES'(1);
         for (int i = 0; i < NUM_STATES; i++) begin
            pm[i] <= '0;
         end
      end else if (clear_i) begin
         valid <= NUM_STATES'(1);
         for (int i = 0; i < NUM_STATES; i++) begin
            pm[i] <= '0;
         end
      end else if (accept_i) begin
         valid <= valid_next;
         for (int i = 0; i < NUM_STATES; i++) begin
            pm[i] <= pm_next[i];
         end
      end
   end

   // Some path always survives
   assert property (@(posedge clk) disable iff (!rst) |valid);

endmodule

`default_nettype wire

//--- hw/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module step_counter
   import viterbi_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clear_i,
   input  logic              inc_i,
   input  logic              dec_i,
   output logic [STEP_W-1:0] step_o,
   output logic              last_o,
   output logic              zero_o
);

   logic [STEP_W-1:0] step;

   // Saturates at both ends of the frame
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         step <= '0;
      end else if (clear_i) begin
         step <= '0;
      end else if (inc_i && !last_o) begin
         step <= step + 1'b1;
      end else if (dec_i && !zero_o) begin
         step <= step - 1'b1;
      end
   end

   assign step_o = step;
   assign last_o = (step == STEP_W'(NUM_STEPS - 1));
   assign zero_o = (step == '0);

endmodule

`default_nettype wire

//--- hw/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl
   import viterbi_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic in_req_i,
   output logic in_ack_o,
   output logic out_req_o,
   input  logic out_ack_i,
   input  logic step_last_i,
   input  logic step_zero_i,
   output logic frame_clear_o,
   output logic accept_o,
   output logic step_inc_o,
   output logic trace_o
);

   ctrl_state_t state;
   ctrl_state_t state_next;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= WAIT_SYM;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next    = state;
      accept_o      = 1'b0;
      step_inc_o    = 1'b0;
      frame_clear_o = 1'b0;
      case (state)
         WAIT_SYM: begin
            // Symbol is taken on the edge that raises ack
            if (in_req_i) begin
               accept_o   = 1'b1;
               state_next = ACK_SYM;
            end
         end
         ACK_SYM: begin
            if (!in_req_i) begin
               if (step_last_i) begin
                  state_next = TRACE;
               end else begin
                  step_inc_o = 1'b1;
                  state_next = WAIT_SYM;
               end
            end
         end
         TRACE: begin
            // Last trace step happens at step 0
            if (step_zero_i) begin
               state_next = OUT_REQ;
            end
         end
         OUT_REQ: begin
            if (out_ack_i) begin
               frame_clear_o = 1'b1;
               state_next    = OUT_DONE;
            end
         end
         OUT_DONE: begin
            if (!out_ack_i) begin
               state_next = WAIT_SYM;
            end
         end
         default: state_next = WAIT_SYM;
      endcase
   end

   assign in_ack_o  = (state == ACK_SYM);
   assign out_req_o = (state == OUT_REQ);
   assign trace_o   = (state == TRACE);

   // Output request drops only after its ack
   assert property (@(posedge clk) disable iff (!rst) $fell(out_req_o) |-> $past(out_ack_i));

   assert property (@(posedge clk) disable iff (!rst) $rose(in_ack_o) |-> $past(in_req_i));

endmodule

`default_nettype wire

//--- hw/viterbi_pkg.sv
`default_nettype none

package viterbi_pkg;

   // Trellis geometry
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;

   // Frame layout
   localparam int MSG_BITS  = 32;
   localparam int TAIL_BITS = 3;
   localparam int NUM_STEPS = MSG_BITS + TAIL_BITS;
   localparam int STEP_W    = 6;

   // Worst case is 2 per step over 35 steps, so 7 bits never wrap
   localparam int METRIC_W = 7;

   // Taps over {input bit, state[2:0]}, input bit in the MSB
   localparam logic [STATE_W:0] GEN0 = 4'o17;
   localparam logic [STATE_W:0] GEN1 = 4'o13;

   // One received symbol pair
   typedef struct packed {
      logic c0;
      logic c1;
   } rx_sym_t;

   // Survivor bit per state, 1 selects the predecessor ending in 1
   typedef logic [NUM_STATES-1:0] decision_t;

   typedef logic [MSG_BITS-1:0] frame_word_t;

   typedef enum logic [2:0] {
      WAIT_SYM,
      ACK_SYM,
      TRACE,
      OUT_REQ,
      OUT_DONE
   } ctrl_state_t;

endpackage

`default_nettype wire
